/* hdl/match_engine_defines.svh */
`ifndef MATCH_ENGINE_DEFINES_SVH
`define MATCH_ENGINE_DEFINES_SVH

// history buffer addressing, 256 bytes
`define ADDR_WIDTH 8

// job PEs on the batch chain and the record ring
`define NUM_JOB_PE 4

// match length field
`define ML_WIDTH 4

// longest match a PE will count
`define MAX_MATCH_LEN 15

// shorter matches are reported as literals
`define MIN_MATCH_LEN 3

`endif

/* hdl/match_engine_pkg.sv */
`include "match_engine_defines.svh"

package match_engine_pkg;

    typedef logic [`ADDR_WIDTH-1:0] addr_t;
    typedef logic [7:0] byte_t;
    typedef logic [`ML_WIDTH-1:0] match_len_t;

    // backward distance from head to candidate
    typedef logic [`ADDR_WIDTH-1:0] offset_t;

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        EMIT
    } pe_state_t;

endpackage

/* hdl/hash_batch_bus_node.sv */
`timescale 1ns/10ps
`include "match_engine_defines.svh"

module hash_batch_bus_node #(
    parameter int IDX = 0
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    i_valid,
    input  match_engine_pkg::addr_t i_head_addr,
    input  logic                    i_history_valid,
    input  match_engine_pkg::addr_t i_history_addr,
    input  logic                    i_delim,
    output logic                    o_ready,

    output logic                    o_this_valid,
    output match_engine_pkg::addr_t o_this_head_addr,
    output logic                    o_this_history_valid,
    output match_engine_pkg::addr_t o_this_history_addr,
    output logic                    o_this_delim,
    input  logic                    i_this_ready,

    output logic                    o_next_valid,
    output match_engine_pkg::addr_t o_next_head_addr,
    output logic                    o_next_history_valid,
    output match_engine_pkg::addr_t o_next_history_addr,
    output logic                    o_next_delim,
    input  logic                    i_next_ready
);
    import match_engine_pkg::*;

    // batches still to be shared among this node and the ones after it
    localparam int NUM_SLOTS = `NUM_JOB_PE - IDX;

    logic                           valid_q;
    logic                           sel_this_q;
    logic [$clog2(`NUM_JOB_PE)-1:0] cnt_q;
    addr_t                          head_q;
    logic                           hist_valid_q;
    addr_t                          hist_addr_q;
    logic                           delim_q;
    logic                           drain;
    logic                           accept;

    assign drain   = valid_q & (sel_this_q ? i_this_ready : i_next_ready);
    assign o_ready = ~valid_q | drain;
    assign accept  = i_valid & o_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q    <= 1'b0;
            sel_this_q <= 1'b0;
            cnt_q      <= '0;
        end else if (accept) begin
            valid_q    <= 1'b1;
            // first batch of each round stays here
            sel_this_q <= (cnt_q == '0);
            if (cnt_q == NUM_SLOTS - 1) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end else if (drain) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            head_q       <= i_head_addr;
            hist_valid_q <= i_history_valid;
            hist_addr_q  <= i_history_addr;
            delim_q      <= i_delim;
        end
    end

    assign o_this_valid         = valid_q & sel_this_q;
    assign o_this_head_addr     = head_q;
    assign o_this_history_valid = hist_valid_q;
    assign o_this_history_addr  = hist_addr_q;
    assign o_this_delim         = delim_q;

    assign o_next_valid         = valid_q & ~sel_this_q;
    assign o_next_head_addr     = head_q;
    assign o_next_history_valid = hist_valid_q;
    assign o_next_history_addr  = hist_addr_q;
    assign o_next_delim         = delim_q;

    // an offered batch is held until this node takes it
    a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (i_valid && !o_ready) |=> (i_valid && $stable(i_head_addr)
            && $stable(i_history_valid) && $stable(i_history_addr) && $stable(i_delim)));

endmodule

/* hdl/history_ram.sv */
`timescale 1ns/10ps
`include "match_engine_defines.svh"

module history_ram (
    input  logic                    clk,

    input  logic                    i_wr_en,
    input  match_engine_pkg::addr_t i_wr_addr,
    input  match_engine_pkg::byte_t i_wr_data,

    input  match_engine_pkg::addr_t i_rd_addr_a,
    input  match_engine_pkg::addr_t i_rd_addr_b,
    output match_engine_pkg::byte_t o_rd_data_a,
    output match_engine_pkg::byte_t o_rd_data_b
);
    import match_engine_pkg::*;

    byte_t mem [1 << `ADDR_WIDTH];

    logic  wr_en_q;
    addr_t wr_addr_q;
    byte_t wr_data_q;

    // write port is staged once before the array
    always_ff @(posedge clk) begin
        wr_en_q   <= i_wr_en;
        wr_addr_q <= i_wr_addr;
        wr_data_q <= i_wr_data;
        if (wr_en_q) begin
            mem[wr_addr_q] <= wr_data_q;
        end
    end

    always_ff @(posedge clk) begin
        o_rd_data_a <= mem[i_rd_addr_a];
        o_rd_data_b <= mem[i_rd_addr_b];
    end

endmodule

/* hdl/job_match_pe.sv */
`timescale 1ns/10ps
`include "match_engine_defines.svh"

module job_match_pe (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         i_batch_valid,
    input  match_engine_pkg::addr_t      i_head_addr,
    input  logic                         i_history_valid,
    input  match_engine_pkg::addr_t      i_history_addr,
    input  logic                         i_delim,
    output logic                         o_batch_ready,

    input  logic                         i_wr_en,
    input  match_engine_pkg::addr_t      i_wr_addr,
    input  match_engine_pkg::byte_t      i_wr_data,

    output logic                         o_seq_valid,
    output match_engine_pkg::match_len_t o_seq_ml,
    output match_engine_pkg::offset_t    o_seq_offset,
    output logic                         o_seq_delim,
    input  logic                         i_seq_ready
);
    import match_engine_pkg::*;

    pe_state_t  state_q;
    addr_t      head_q;
    addr_t      hist_addr_q;
    logic       hist_valid_q;
    logic       delim_q;
    match_len_t rd_idx_q;
    match_len_t ml_q;
    logic       rd_vld_q;
    addr_t      rd_addr_a;
    addr_t      rd_addr_b;
    byte_t      rd_data_a;
    byte_t      rd_data_b;
    logic       report;

    // one byte pair issued per compare cycle, wraps at the buffer end
    assign rd_addr_a = head_q + addr_t'(rd_idx_q);
    assign rd_addr_b = hist_addr_q + addr_t'(rd_idx_q);

    history_ram u_history_ram (
        .clk         (clk),
        .i_wr_en     (i_wr_en),
        .i_wr_addr   (i_wr_addr),
        .i_wr_data   (i_wr_data),
        .i_rd_addr_a (rd_addr_a),
        .i_rd_addr_b (rd_addr_b),
        .o_rd_data_a (rd_data_a),
        .o_rd_data_b (rd_data_b)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= IDLE;
            rd_idx_q <= '0;
            ml_q     <= '0;
            rd_vld_q <= 1'b0;
        end else begin
            // read data lags the issued address by one cycle
            rd_vld_q <= (state_q == COMPARE);
            case (state_q)
                IDLE: begin
                    if (i_batch_valid) begin
                        state_q  <= COMPARE;
                        rd_idx_q <= '0;
                        ml_q     <= '0;
                    end
                end
                COMPARE: begin
                    rd_idx_q <= rd_idx_q + 1'b1;
                    if (rd_vld_q) begin
                        if (rd_data_a == rd_data_b) begin
                            ml_q <= ml_q + 1'b1;
                            if (ml_q == match_len_t'(`MAX_MATCH_LEN - 1)) begin
                                state_q <= EMIT;
                            end
                        end else begin
                            state_q <= EMIT;
                        end
                    end
                end
                EMIT: begin
                    if (i_seq_ready) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && i_batch_valid) begin
            head_q       <= i_head_addr;
            hist_addr_q  <= i_history_addr;
            hist_valid_q <= i_history_valid;
            delim_q      <= i_delim;
        end
    end

    // short or invalid candidates come out as a plain literal record
    assign report = hist_valid_q && (ml_q >= match_len_t'(`MIN_MATCH_LEN));

    assign o_batch_ready = (state_q == IDLE);
    assign o_seq_valid   = (state_q == EMIT);
    assign o_seq_ml      = report ? ml_q : '0;
    assign o_seq_offset  = report ? offset_t'(head_q - hist_addr_q) : '0;
    assign o_seq_delim   = delim_q;

    // a pending record stays put until the ring takes it
    a_rec_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (o_seq_valid && !i_seq_ready) |=> (o_seq_valid && $stable(o_seq_ml)
            && $stable(o_seq_offset) && $stable(o_seq_delim)));

endmodule

/* hdl/seq_packet_bus_node.sv */
`timescale 1ns/10ps
`include "match_engine_defines.svh"

module seq_packet_bus_node #(
    parameter int IDX = 0
) (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         i_token_valid,
    output logic                         o_token_ready,
    output logic                         o_token_valid,
    input  logic                         i_token_ready,

    input  logic                         i_local_valid,
    input  match_engine_pkg::match_len_t i_local_ml,
    input  match_engine_pkg::offset_t    i_local_offset,
    input  logic                         i_local_delim,
    output logic                         o_local_ready,

    input  logic                         i_prev_valid,
    input  match_engine_pkg::match_len_t i_prev_ml,
    input  match_engine_pkg::offset_t    i_prev_offset,
    input  logic                         i_prev_delim,
    output logic                         o_prev_ready,

    output logic                         o_next_valid,
    output match_engine_pkg::match_len_t o_next_ml,
    output match_engine_pkg::offset_t    o_next_offset,
    output logic                         o_next_delim,
    input  logic                         i_next_ready
);
    import match_engine_pkg::*;

    logic has_token_q;
    logic tok_out_q;
    logic can_load;
    logic load_prev;
    logic load_local;

    assign can_load      = ~o_next_valid | i_next_ready;
    assign o_prev_ready  = can_load;
    // own record only goes in behind everything from upstream
    assign o_local_ready = can_load & has_token_q & ~i_prev_valid;
    assign load_prev     = i_prev_valid & can_load;
    assign load_local    = i_local_valid & o_local_ready;

    assign o_token_valid = tok_out_q;
    assign o_token_ready = ~has_token_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            has_token_q  <= (IDX == 0);
            tok_out_q    <= 1'b0;
            o_next_valid <= 1'b0;
        end else begin
            if (load_prev || load_local) begin
                o_next_valid <= 1'b1;
            end else if (i_next_ready) begin
                o_next_valid <= 1'b0;
            end
            if (load_local) begin
                has_token_q <= 1'b0;
                tok_out_q   <= 1'b1;
            end else if (i_token_valid && o_token_ready) begin
                has_token_q <= 1'b1;
            end
            if (tok_out_q && i_token_ready) begin
                tok_out_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_prev) begin
            o_next_ml     <= i_prev_ml;
            o_next_offset <= i_prev_offset;
            o_next_delim  <= i_prev_delim;
        end else if (load_local) begin
            o_next_ml     <= i_local_ml;
            o_next_offset <= i_local_offset;
            o_next_delim  <= i_local_delim;
        end
    end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (o_next_valid && !i_next_ready) |=> (o_next_valid && $stable(o_next_ml)
            && $stable(o_next_offset) && $stable(o_next_delim)));

endmodule

/* hdl/match_engine.sv */
`timescale 1ns/10ps
`include "match_engine_defines.svh"

module match_engine (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         i_hash_valid,
    input  match_engine_pkg::addr_t      i_hash_head_addr,
    input  logic                         i_hash_history_valid,
    input  match_engine_pkg::addr_t      i_hash_history_addr,
    input  logic                         i_hash_delim,
    output logic                         o_hash_ready,

    output logic                         o_seq_valid,
    output match_engine_pkg::match_len_t o_seq_ml,
    output match_engine_pkg::offset_t    o_seq_offset,
    output logic                         o_seq_delim,
    input  logic                         i_seq_ready,

    input  logic                         i_wr_en,
    input  match_engine_pkg::addr_t      i_wr_addr,
    input  match_engine_pkg::byte_t      i_wr_data
);
    import match_engine_pkg::*;

    localparam int N = `NUM_JOB_PE;

    // batch chain, entry 0 is the top input and entry i+1 leaves node i
    wire        hb_valid      [N+1];
    wire addr_t hb_head       [N+1];
    wire        hb_hist_valid [N+1];
    wire addr_t hb_hist_addr  [N+1];
    wire        hb_delim      [N+1];
    wire        hb_ready      [N+1];

    // node to PE
    wire        pe_valid      [N];
    wire addr_t pe_head       [N];
    wire        pe_hist_valid [N];
    wire addr_t pe_hist_addr  [N];
    wire        pe_delim      [N];
    wire        pe_ready      [N];

    // PE to ring node
    wire             lc_valid  [N];
    wire match_len_t lc_ml     [N];
    wire offset_t    lc_offset [N];
    wire             lc_delim  [N];
    wire             lc_ready  [N];

    // record ring, entry 0 is tied idle and entry N is the top output
    wire             sq_valid  [N+1];
    wire match_len_t sq_ml     [N+1];
    wire offset_t    sq_offset [N+1];
    wire             sq_delim  [N+1];
    wire             sq_ready  [N+1];

    wire tok_valid [N];
    wire tok_ready [N];

    assign hb_valid[0]      = i_hash_valid;
    assign hb_head[0]       = i_hash_head_addr;
    assign hb_hist_valid[0] = i_hash_history_valid;
    assign hb_hist_addr[0]  = i_hash_history_addr;
    assign hb_delim[0]      = i_hash_delim;
    assign o_hash_ready     = hb_ready[0];
    assign hb_ready[N]      = 1'b0;

    assign sq_valid[0]  = 1'b0;
    assign sq_ml[0]     = '0;
    assign sq_offset[0] = '0;
    assign sq_delim[0]  = 1'b0;
    assign o_seq_valid  = sq_valid[N];
    assign o_seq_ml     = sq_ml[N];
    assign o_seq_offset = sq_offset[N];
    assign o_seq_delim  = sq_delim[N];
    assign sq_ready[N]  = i_seq_ready;

    for (genvar i = 0; i < N; i++) begin : g_lane
        hash_batch_bus_node #(.IDX(i)) u_hbbn (
            .clk                  (clk),
            .rst_n                (rst_n),
            .i_valid              (hb_valid[i]),
            .i_head_addr          (hb_head[i]),
            .i_history_valid      (hb_hist_valid[i]),
            .i_history_addr       (hb_hist_addr[i]),
            .i_delim              (hb_delim[i]),
            .o_ready              (hb_ready[i]),
            .o_this_valid         (pe_valid[i]),
            .o_this_head_addr     (pe_head[i]),
            .o_this_history_valid (pe_hist_valid[i]),
            .o_this_history_addr  (pe_hist_addr[i]),
            .o_this_delim         (pe_delim[i]),
            .i_this_ready         (pe_ready[i]),
            .o_next_valid         (hb_valid[i+1]),
            .o_next_head_addr     (hb_head[i+1]),
            .o_next_history_valid (hb_hist_valid[i+1]),
            .o_next_history_addr  (hb_hist_addr[i+1]),
            .o_next_delim         (hb_delim[i+1]),
            .i_next_ready         (hb_ready[i+1])
        );

        job_match_pe u_pe (
            .clk             (clk),
            .rst_n           (rst_n),
            .i_batch_valid   (pe_valid[i]),
            .i_head_addr     (pe_head[i]),
            .i_history_valid (pe_hist_valid[i]),
            .i_history_addr  (pe_hist_addr[i]),
            .i_delim         (pe_delim[i]),
            .o_batch_ready   (pe_ready[i]),
            .i_wr_en         (i_wr_en),
            .i_wr_addr       (i_wr_addr),
            .i_wr_data       (i_wr_data),
            .o_seq_valid     (lc_valid[i]),
            .o_seq_ml        (lc_ml[i]),
            .o_seq_offset    (lc_offset[i]),
            .o_seq_delim     (lc_delim[i]),
            .i_seq_ready     (lc_ready[i])
        );

        // token comes from the node before, node 0 closes the ring
        seq_packet_bus_node #(.IDX(i)) u_spbn (
            .clk            (clk),
            .rst_n          (rst_n),
            .i_token_valid  (tok_valid[(i + N - 1) % N]),
            .o_token_ready  (tok_ready[i]),
            .o_token_valid  (tok_valid[i]),
            .i_token_ready  (tok_ready[(i + 1) % N]),
            .i_local_valid  (lc_valid[i]),
            .i_local_ml     (lc_ml[i]),
            .i_local_offset (lc_offset[i]),
            .i_local_delim  (lc_delim[i]),
            .o_local_ready  (lc_ready[i]),
            .i_prev_valid   (sq_valid[i]),
            .i_prev_ml      (sq_ml[i]),
            .i_prev_offset  (sq_offset[i]),
            .i_prev_delim   (sq_delim[i]),
            .o_prev_ready   (sq_ready[i]),
            .o_next_valid   (sq_valid[i+1]),
            .o_next_ml      (sq_ml[i+1]),
            .o_next_offset  (sq_offset[i+1]),
            .o_next_delim   (sq_delim[i+1]),
            .i_next_ready   (sq_ready[i+1])
        );
    end

endmodule

/* test/match_engine_tb.sv */
`timescale 1ns/10ps
`include "match_engine_defines.svh"

module match_engine_tb;
    import match_engine_pkg::*;

    localparam int WAIT_LIMIT    = 1000;
    localparam int RANDOM_CYCLES = 40;
    localparam int STALL_CYCLES  = 200;

    logic       clk;
    logic       rst_n;
    logic       i_hash_valid;
    addr_t      i_hash_head_addr;
    logic       i_hash_history_valid;
    addr_t      i_hash_history_addr;
    logic       i_hash_delim;
    logic       o_hash_ready;
    logic       o_seq_valid;
    match_len_t o_seq_ml;
    offset_t    o_seq_offset;
    logic       o_seq_delim;
    logic       i_seq_ready;
    logic       i_wr_en;
    addr_t      i_wr_addr;
    byte_t      i_wr_data;

    // reference copy of the history buffer
    byte_t hist_mem [1 << `ADDR_WIDTH];

    // one row per batch, expected record alongside
    addr_t tbl_head  [$];
    addr_t tbl_hist  [$];
    logic  tbl_hv    [$];
    logic  tbl_delim [$];
    int    exp_ml    [$];
    int    exp_off   [$];

    match_engine uut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_hash_valid         (i_hash_valid),
        .i_hash_head_addr     (i_hash_head_addr),
        .i_hash_history_valid (i_hash_history_valid),
        .i_hash_history_addr  (i_hash_history_addr),
        .i_hash_delim         (i_hash_delim),
        .o_hash_ready         (o_hash_ready),
        .o_seq_valid          (o_seq_valid),
        .o_seq_ml             (o_seq_ml),
        .o_seq_offset         (o_seq_offset),
        .o_seq_delim          (o_seq_delim),
        .i_seq_ready          (i_seq_ready),
        .i_wr_en              (i_wr_en),
        .i_wr_addr            (i_wr_addr),
        .i_wr_data            (i_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic wait_expired(input string what);
        $display("timeout while waiting for %s", what);
        abort_run();
    endtask

    // count equal bytes from both addresses, then apply the record rule
    function automatic void ref_match(input addr_t head, input addr_t hist, input logic hv,
                                      output int ml, output int off);
        int   n;
        int   run;
        logic stop;
        run  = 0;
        stop = 1'b0;
        for (n = 0; n < `MAX_MATCH_LEN; n++) begin
            if (!stop) begin
                if (hist_mem[head + addr_t'(n)] == hist_mem[hist + addr_t'(n)]) begin
                    run++;
                end else begin
                    stop = 1'b1;
                end
            end
        end
        if (hv && run >= `MIN_MATCH_LEN) begin
            ml  = run;
            off = int'(addr_t'(head - hist));
        end else begin
            ml  = 0;
            off = 0;
        end
    endfunction

    task automatic plant_run(input addr_t src, input addr_t dst, input int len);
        int i;
        for (i = 0; i < len; i++) begin
            hist_mem[dst + addr_t'(i)] = hist_mem[src + addr_t'(i)];
        end
    endtask

    task automatic build_history();
        int a;
        // odd multiplier keeps every base byte distinct
        for (a = 0; a < (1 << `ADDR_WIDTH); a++) begin
            hist_mem[addr_t'(a)] = byte_t'(a * 167 + 13);
        end
        plant_run(8'h10, 8'h80, 20);
        plant_run(8'h30, 8'hb0, 3);
        plant_run(8'h38, 8'hc0, 7);
        plant_run(8'h40, 8'hd0, 14);
        plant_run(8'h50, 8'he8, 2);
        plant_run(8'h58, 8'hf0, 5);
        // wraps past the top of the buffer
        plant_run(8'h60, 8'hfc, 9);
        plant_run(8'h20, 8'h70, 12);
    endtask

    task automatic add_entry(input addr_t head, input addr_t hist, input logic hv,
                             input logic delim);
        int ml;
        int off;
        ref_match(head, hist, hv, ml, off);
        tbl_head.push_back(head);
        tbl_hist.push_back(hist);
        tbl_hv.push_back(hv);
        tbl_delim.push_back(delim);
        exp_ml.push_back(ml);
        exp_off.push_back(off);
    endtask

    task automatic build_table();
        //        head   hist   hv    delim
        add_entry(8'h80, 8'h10, 1'b1, 1'b0);
        add_entry(8'hb0, 8'h30, 1'b1, 1'b0);
        add_entry(8'hc0, 8'h38, 1'b1, 1'b1);
        add_entry(8'hd0, 8'h40, 1'b1, 1'b0);
        add_entry(8'he8, 8'h50, 1'b1, 1'b0);
        add_entry(8'hf0, 8'h58, 1'b1, 1'b1);
        add_entry(8'hfc, 8'h60, 1'b1, 1'b0);
        add_entry(8'h70, 8'h20, 1'b1, 1'b0);
        add_entry(8'h86, 8'h16, 1'b1, 1'b1);
        add_entry(8'h89, 8'h19, 1'b1, 1'b0);
        add_entry(8'h8c, 8'h1c, 1'b1, 1'b0);
        add_entry(8'h90, 8'h20, 1'b1, 1'b1);
        // long match but no valid candidate
        add_entry(8'h80, 8'h10, 1'b0, 1'b0);
        add_entry(8'h05, 8'h06, 1'b1, 1'b0);
        add_entry(8'h44, 8'h44, 1'b1, 1'b1);
        add_entry(8'hc4, 8'h3c, 1'b1, 1'b0);
        add_entry(8'hd5, 8'h45, 1'b1, 1'b0);
        add_entry(8'h92, 8'h22, 1'b1, 1'b1);
        add_entry(8'h81, 8'h11, 1'b1, 1'b0);
        add_entry(8'h20, 8'h10, 1'b1, 1'b0);
    endtask

    task automatic load_history();
        int a;
        for (a = 0; a < (1 << `ADDR_WIDTH); a++) begin
            @(posedge clk);
            #1;
            i_wr_en   = 1'b1;
            i_wr_addr = addr_t'(a);
            i_wr_data = hist_mem[addr_t'(a)];
        end
        @(posedge clk);
        #1;
        i_wr_en = 1'b0;
        // let the staged writes land in every RAM
        repeat (4) @(posedge clk);
    endtask

    task automatic check_idle(input int cycles);
        int c;
        for (c = 0; c < cycles; c++) begin
            @(negedge clk);
            check_eq("o_seq_valid while idle", int'(o_seq_valid), 0);
        end
    endtask

    task automatic send_table(input int count);
        int k;
        int e;
        int waited;
        @(posedge clk);
        #1;
        for (k = 0; k < count; k++) begin
            e = k % tbl_head.size();
            i_hash_valid         = 1'b1;
            i_hash_head_addr     = tbl_head[e];
            i_hash_history_addr  = tbl_hist[e];
            i_hash_history_valid = tbl_hv[e];
            i_hash_delim         = tbl_delim[e];
            waited = 0;
            @(negedge clk);
            while (!o_hash_ready) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    wait_expired("the batch chain to accept a batch");
                end
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        i_hash_valid = 1'b0;
    endtask

    // records must come back in batch order
    task automatic collect_records(input int count);
        int got;
        int e;
        int waited;
        got    = 0;
        waited = 0;
        while (got < count) begin
            @(negedge clk);
            if (o_seq_valid && i_seq_ready) begin
                e = got % exp_ml.size();
                check_eq($sformatf("record %0d ml", got), int'(o_seq_ml), exp_ml[e]);
                check_eq($sformatf("record %0d offset", got), int'(o_seq_offset), exp_off[e]);
                check_eq($sformatf("record %0d delim", got), int'(o_seq_delim),
                         int'(tbl_delim[e]));
                got++;
                waited = 0;
            end else begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    wait_expired("a sequence record");
                end
            end
        end
    endtask

    task automatic pace_seq_ready();
        int   c;
        logic saw_full;
        for (c = 0; c < RANDOM_CYCLES; c++) begin
            @(posedge clk);
            #1;
            i_seq_ready = ($urandom % 2) != 0;
        end
        @(posedge clk);
        #1;
        i_seq_ready = 1'b0;
        saw_full    = 1'b0;
        for (c = 0; c < STALL_CYCLES; c++) begin
            @(negedge clk);
            if (i_hash_valid && !o_hash_ready) begin
                saw_full = 1'b1;
            end
        end
        check_eq("o_hash_ready falling under a stalled output", int'(saw_full), 1);
        @(posedge clk);
        #1;
        i_seq_ready = 1'b1;
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 0);
        void'($urandom(32'hc43f));
        rst_n                = 1'b0;
        i_hash_valid         = 1'b0;
        i_hash_head_addr     = '0;
        i_hash_history_valid = 1'b0;
        i_hash_history_addr  = '0;
        i_hash_delim         = 1'b0;
        i_seq_ready          = 1'b1;
        i_wr_en              = 1'b0;
        i_wr_addr            = '0;
        i_wr_data            = '0;

        build_history();
        build_table();

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_idle(16);

        load_history();

        // back to back over all four PEs
        fork
            send_table(tbl_head.size());
            collect_records(tbl_head.size());
        join
        check_idle(20);

        // random back-pressure, then a long stall
        fork
            send_table(2 * tbl_head.size());
            collect_records(2 * tbl_head.size());
            pace_seq_ready();
        join
        check_idle(50);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* match_engine.f */
+incdir+hdl
hdl/match_engine_pkg.sv
hdl/hash_batch_bus_node.sv
hdl/history_ram.sv
hdl/job_match_pe.sv
hdl/seq_packet_bus_node.sv
hdl/match_engine.sv
test/match_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the match engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module match_engine_tb \
    -f match_engine.f -o match_engine_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/match_engine_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "SIMULATION PASSED" "$LOG"; then
    exit 0
fi
exit 1
